//--- include/ecc_field_macros.svh
`ifndef ECC_FIELD_MACROS_SVH
`define ECC_FIELD_MACROS_SVH

// Width of one stored residue
`define ECC_WORD_WIDTH 32

// Mersenne prime 2^31-1, field modulus
`define ECC_PRIME 32'h7fff_ffff

// Register file geometry
`define ECC_REG_COUNT 16

// Highest writable register, everything above is constant
`define ECC_LAST_GPR 12

// Curve constant (A-2)/4 held in reg_a24
`define ECC_CONST_121665 32'd121665

`endif

//--- rtl/ecc_reg_pkg.sv
`include "ecc_field_macros.svh"

package ecc_reg_pkg;

	// Register identifiers
	// r0..r12 are general purpose, top three are read-only constants
	typedef enum logic [3:0] {
		reg_r0   = 4'd0,
		reg_r1   = 4'd1,
		reg_r2   = 4'd2,
		reg_r3   = 4'd3,
		reg_r4   = 4'd4,
		reg_r5   = 4'd5,
		reg_r6   = 4'd6,
		reg_r7   = 4'd7,
		reg_r8   = 4'd8,
		reg_r9   = 4'd9,
		reg_r10  = 4'd10,
		reg_r11  = 4'd11,
		reg_r12  = 4'd12,
		reg_zero = 4'd13,
		reg_one  = 4'd14,
		reg_a24  = 4'd15
	} regid_t;

	// One field residue, kept below the prime
	typedef logic [`ECC_WORD_WIDTH-1:0] regval_t;

endpackage

//--- rtl/ecc_op_pkg.sv
package ecc_op_pkg;

	// Add/sub unit opcodes
	typedef enum logic [1:0] {
		op_nop    = 2'd0,
		op_add    = 2'd1,
		op_sub    = 2'd2,
		// Both results, retired together on both write ports
		op_addsub = 2'd3
	} opcode_t;

	// One issued operation as seen at the core boundary
	typedef struct packed {
		opcode_t             op;
		ecc_reg_pkg::regid_t src_a;
		ecc_reg_pkg::regid_t src_b;
		// Sum goes out on write port 0
		ecc_reg_pkg::regid_t dst_sum;
		// Difference goes out on write port 1
		ecc_reg_pkg::regid_t dst_diff;
	} issue_t;

endpackage

//--- rtl/retire_if.sv
`timescale 1ns/100ps

// One retiring result, unit to register file
interface retire_if;

	// Result register holds live data this cycle
	logic valid;

	// Opcode asked for this result, otherwise it is dropped
	logic want;

	// Destination register and its new value
	ecc_reg_pkg::regid_t  dst;
	ecc_reg_pkg::regval_t data;

	// Arithmetic unit side
	modport source (output valid, output want, output dst, output data);

	// Register file side
	modport sink (input valid, input want, input dst, input data);

endinterface

//--- rtl/regfile_bank.sv
`timescale 1ns/100ps
`include "ecc_field_macros.svh"

// One bank of the register file
// Single write port, three combinational read ports
module regfile_bank (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 wr_en,
	input  ecc_reg_pkg::regid_t  wr_addr,
	input  ecc_reg_pkg::regval_t wr_data,

	input  ecc_reg_pkg::regid_t  rd_addr0,
	input  ecc_reg_pkg::regid_t  rd_addr1,
	input  ecc_reg_pkg::regid_t  rd_addr2,

	output ecc_reg_pkg::regval_t rd_data0,
	output ecc_reg_pkg::regval_t rd_data1,
	output ecc_reg_pkg::regval_t rd_data2
);

	//////////////////////////////////////////////////
	// Storage

	ecc_reg_pkg::regval_t mem [0:`ECC_REG_COUNT-1];

	// Reset wipes the GPRs and seeds the constants
	// reg_zero just stays at zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `ECC_REG_COUNT; i++) begin
				mem[i] <= '0;
			end
			mem[ecc_reg_pkg::reg_one] <= ecc_reg_pkg::regval_t'(1);
			mem[ecc_reg_pkg::reg_a24] <= `ECC_CONST_121665;
		end else if (wr_en) begin
			// Constant protection lives in the arbiter
			mem[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports

	// Async reads, registered one level up
	assign rd_data0 = mem[rd_addr0];
	assign rd_data1 = mem[rd_addr1];
	assign rd_data2 = mem[rd_addr2];

endmodule

//--- rtl/regfile.sv
`timescale 1ns/100ps
`include "ecc_field_macros.svh"

// Two-write, three-read register file
// Built from two single-write banks plus a live value table
module regfile (
	input  logic                 clk,
	input  logic                 rst_n,

	// Retiring results from the add/sub unit
	retire_if.sink               sum_retire,
	retire_if.sink               diff_retire,

	// External operand load, shares write port 0
	input  logic                 load_en,
	input  ecc_reg_pkg::regid_t  load_addr,
	input  ecc_reg_pkg::regval_t load_data,

	// Operand fetch for the add/sub unit
	input  logic                 rd_en,
	input  ecc_reg_pkg::regid_t  src_a,
	input  ecc_reg_pkg::regid_t  src_b,

	// Host read-back
	input  logic                 rd_req,
	input  ecc_reg_pkg::regid_t  rd_addr,

	output ecc_reg_pkg::regval_t opnd_a,
	output ecc_reg_pkg::regval_t opnd_b,
	output ecc_reg_pkg::regval_t rd_data,
	output logic                 rd_valid
);

	//////////////////////////////////////////////////
	// Write arbitration

	logic                 p0_wr_en;
	ecc_reg_pkg::regid_t  p0_wr_addr;
	ecc_reg_pkg::regval_t p0_wr_data;

	logic                 p1_wr_en;
	ecc_reg_pkg::regid_t  p1_wr_addr;
	ecc_reg_pkg::regval_t p1_wr_data;

	always_comb begin
		// Port 0 defaults to the sum retire
		p0_wr_en   = sum_retire.valid && sum_retire.want;
		p0_wr_addr = sum_retire.dst;
		p0_wr_data = sum_retire.data;

		// Load takes port 0 over a sum retire
		if (load_en) begin
			p0_wr_en   = 1'b1;
			p0_wr_addr = load_addr;
			p0_wr_data = load_data;
		end

		// Port 1 only ever carries the difference
		p1_wr_en   = diff_retire.valid && diff_retire.want;
		p1_wr_addr = diff_retire.dst;
		p1_wr_data = diff_retire.data;

		// Constants are read only
		if (p0_wr_addr > 4'(`ECC_LAST_GPR)) begin
			p0_wr_en = 1'b0;
		end
		if (p1_wr_addr > 4'(`ECC_LAST_GPR)) begin
			p1_wr_en = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Read address muxing

	// Index 0/1 feed the operands, 2 feeds read-back
	ecc_reg_pkg::regid_t  rd_addr_p [3];
	ecc_reg_pkg::regval_t data_b0   [3];
	ecc_reg_pkg::regval_t data_b1   [3];
	ecc_reg_pkg::regval_t data_p    [3];

	// Idle ports park on reg_zero
	always_comb begin
		rd_addr_p[0] = rd_en  ? src_a   : ecc_reg_pkg::reg_zero;
		rd_addr_p[1] = rd_en  ? src_b   : ecc_reg_pkg::reg_zero;
		rd_addr_p[2] = rd_req ? rd_addr : ecc_reg_pkg::reg_zero;
	end

	//////////////////////////////////////////////////
	// Banks

	// Bank 0 takes port 0 writes
	regfile_bank bank0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (p0_wr_en),
		.wr_addr  (p0_wr_addr),
		.wr_data  (p0_wr_data),
		.rd_addr0 (rd_addr_p[0]),
		.rd_addr1 (rd_addr_p[1]),
		.rd_addr2 (rd_addr_p[2]),
		.rd_data0 (data_b0[0]),
		.rd_data1 (data_b0[1]),
		.rd_data2 (data_b0[2])
	);

	// Bank 1 takes port 1 writes
	regfile_bank bank1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (p1_wr_en),
		.wr_addr  (p1_wr_addr),
		.wr_data  (p1_wr_data),
		.rd_addr0 (rd_addr_p[0]),
		.rd_addr1 (rd_addr_p[1]),
		.rd_addr2 (rd_addr_p[2]),
		.rd_data0 (data_b1[0]),
		.rd_data1 (data_b1[1]),
		.rd_data2 (data_b1[2])
	);

	//////////////////////////////////////////////////
	// Live value table

	// One bit per register, set means bank 1 has the latest copy
	logic [`ECC_REG_COUNT-1:0] lvt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lvt <= '0;
		end else begin
			if (p0_wr_en) begin
				lvt[p0_wr_addr] <= 1'b0;
			end
			// Same address on both ports, bank 1 wins
			if (p1_wr_en) begin
				lvt[p1_wr_addr] <= 1'b1;
			end
		end
	end

	// Pick the live bank per read port
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			data_p[i] = lvt[rd_addr_p[i]] ? data_b1[i] : data_b0[i];
		end
	end

	//////////////////////////////////////////////////
	// Output registers

	// Operand latches, held between issues
	always_ff @(posedge clk) begin
		if (rd_en) begin
			opnd_a <= data_p[0];
			opnd_b <= data_p[1];
		end
		if (rd_req) begin
			rd_data <= data_p[2];
		end
	end

	// Read-back strobe, one cycle per request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_req;
		end
	end

endmodule

//--- rtl/modaddsub_unit.sv
`timescale 1ns/100ps
`include "ecc_field_macros.svh"

// Modular add/subtract mod 2^31-1
// One cycle of compute, results retire on two ports
module modaddsub_unit (
	input  logic                 clk,
	input  logic                 rst_n,

	input  ecc_reg_pkg::regval_t opnd_a,
	input  ecc_reg_pkg::regval_t opnd_b,
	input  logic                 op_valid,
	input  ecc_op_pkg::opcode_t  op,
	input  ecc_reg_pkg::regid_t  sum_dst,
	input  ecc_reg_pkg::regid_t  diff_dst,

	retire_if.source             sum_retire,
	retire_if.source             diff_retire
);

	//////////////////////////////////////////////////
	// Issue alignment

	// Opcode and targets arrive with the fetch
	// Held one cycle so they meet the registered operands
	ecc_op_pkg::opcode_t op_q;
	ecc_reg_pkg::regid_t sum_dst_q;
	ecc_reg_pkg::regid_t diff_dst_q;

	always_ff @(posedge clk) begin
		op_q       <= op;
		sum_dst_q  <= sum_dst;
		diff_dst_q <= diff_dst;
	end

	//////////////////////////////////////////////////
	// Arithmetic

	logic [`ECC_WORD_WIDTH:0] sum_raw;
	ecc_reg_pkg::regval_t     sum_mod;
	ecc_reg_pkg::regval_t     diff_raw;
	ecc_reg_pkg::regval_t     diff_mod;

	// Inputs are both below p, so one correction is enough
	assign sum_raw = {1'b0, opnd_a} + {1'b0, opnd_b};
	assign sum_mod = (sum_raw >= {1'b0, `ECC_PRIME}) ?
		ecc_reg_pkg::regval_t'(sum_raw - {1'b0, `ECC_PRIME}) :
		sum_raw[`ECC_WORD_WIDTH-1:0];

	// Borrow means wrap back up by p
	assign diff_raw = opnd_a - opnd_b;
	assign diff_mod = (opnd_a < opnd_b) ? diff_raw + `ECC_PRIME : diff_raw;

	//////////////////////////////////////////////////
	// Result registers

	// Valid and want are control, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_retire.valid  <= 1'b0;
			sum_retire.want   <= 1'b0;
			diff_retire.valid <= 1'b0;
			diff_retire.want  <= 1'b0;
		end else begin
			sum_retire.valid  <= op_valid;
			sum_retire.want   <= op_q inside {ecc_op_pkg::op_add, ecc_op_pkg::op_addsub};
			diff_retire.valid <= op_valid;
			diff_retire.want  <= op_q inside {ecc_op_pkg::op_sub, ecc_op_pkg::op_addsub};
		end
	end

	// Payload, meaningful only under valid
	always_ff @(posedge clk) begin
		sum_retire.dst   <= sum_dst_q;
		sum_retire.data  <= sum_mod;
		diff_retire.dst  <= diff_dst_q;
		diff_retire.data <= diff_mod;
	end

endmodule

//--- rtl/ecc_field_core.sv
`timescale 1ns/100ps

// Field arithmetic datapath, top level
module ecc_field_core (
	input  logic                 clk,
	input  logic                 rst_n,

	// Operand load
	input  logic                 load_en,
	input  ecc_reg_pkg::regid_t  load_addr,
	input  ecc_reg_pkg::regval_t load_data,

	// Operation issue
	input  logic                 issue_en,
	input  ecc_op_pkg::opcode_t  issue_op,
	input  ecc_reg_pkg::regid_t  issue_src_a,
	input  ecc_reg_pkg::regid_t  issue_src_b,
	input  ecc_reg_pkg::regid_t  issue_dst_sum,
	input  ecc_reg_pkg::regid_t  issue_dst_diff,

	// Read-back
	input  logic                 rd_req,
	input  ecc_reg_pkg::regid_t  rd_addr,
	output ecc_reg_pkg::regval_t rd_data,
	output logic                 rd_valid
);

	//////////////////////////////////////////////////
	// Issue capture

	ecc_op_pkg::issue_t   issue;
	logic                 op_valid;
	ecc_reg_pkg::regval_t opnd_a;
	ecc_reg_pkg::regval_t opnd_b;

	assign issue = '{
		op:       issue_op,
		src_a:    issue_src_a,
		src_b:    issue_src_b,
		dst_sum:  issue_dst_sum,
		dst_diff: issue_dst_diff
	};

	// Valid trails the fetch by one cycle, lining up with the operand registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= issue_en;
		end
	end

	//////////////////////////////////////////////////
	// Datapath

	// Port 0 carries sums, port 1 differences
	retire_if sum_retire ();
	retire_if diff_retire ();

	regfile i_regfile (
		.clk         (clk),
		.rst_n       (rst_n),
		.sum_retire  (sum_retire),
		.diff_retire (diff_retire),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.rd_en       (issue_en),
		.src_a       (issue.src_a),
		.src_b       (issue.src_b),
		.rd_req      (rd_req),
		.rd_addr     (rd_addr),
		.opnd_a      (opnd_a),
		.opnd_b      (opnd_b),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid)
	);

	modaddsub_unit i_addsub (
		.clk         (clk),
		.rst_n       (rst_n),
		.opnd_a      (opnd_a),
		.opnd_b      (opnd_b),
		.op_valid    (op_valid),
		.op          (issue.op),
		.sum_dst     (issue.dst_sum),
		.diff_dst    (issue.dst_diff),
		.sum_retire  (sum_retire),
		.diff_retire (diff_retire)
	);

endmodule

//--- tests/tb_ecc_field_core.sv
`timescale 1ns/100ps
`include "ecc_field_macros.svh"

// Testbench for the field arithmetic core
module tb_ecc_field_core;

	localparam logic [31:0] SEED_INIT = 32'h0bc5_0fa9;
	// Cycles allowed for rd_valid to show up
	localparam int TIMEOUT_CYCLES = 20;
	// Issue sample to bank write, plus the read-before-write edge
	localparam int RETIRE_LATENCY = 3;

	logic                 clk;
	logic                 rst_n;
	logic                 load_en;
	ecc_reg_pkg::regid_t  load_addr;
	ecc_reg_pkg::regval_t load_data;
	logic                 issue_en;
	ecc_op_pkg::opcode_t  issue_op;
	ecc_reg_pkg::regid_t  issue_src_a;
	ecc_reg_pkg::regid_t  issue_src_b;
	ecc_reg_pkg::regid_t  issue_dst_sum;
	ecc_reg_pkg::regid_t  issue_dst_diff;
	logic                 rd_req;
	ecc_reg_pkg::regid_t  rd_addr;
	ecc_reg_pkg::regval_t rd_data;
	logic                 rd_valid;

	// Reference register contents
	ecc_reg_pkg::regval_t model [`ECC_REG_COUNT];

	integer seed;
	int     errors;
	int     checks;
	int     tests;
	int     errs_at_start;
	string  cur_test;

	ecc_field_core i_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.load_en        (load_en),
		.load_addr      (load_addr),
		.load_data      (load_data),
		.issue_en       (issue_en),
		.issue_op       (issue_op),
		.issue_src_a    (issue_src_a),
		.issue_src_b    (issue_src_b),
		.issue_dst_sum  (issue_dst_sum),
		.issue_dst_diff (issue_dst_diff),
		.rd_req         (rd_req),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.rd_valid       (rd_valid)
	);

	// 40 ns period
	always #20 clk = ~clk;

	//////////////////////////////////////////////////
	// Reference arithmetic

	// Sum reduced by the modulus
	function automatic ecc_reg_pkg::regval_t mod_add(input ecc_reg_pkg::regval_t a,
		input ecc_reg_pkg::regval_t b);
		logic [63:0] s;
		s = 64'(a) + 64'(b);
		return ecc_reg_pkg::regval_t'(s % 64'(`ECC_PRIME));
	endfunction

	// Difference, lifted by p so it never goes negative
	function automatic ecc_reg_pkg::regval_t mod_sub(input ecc_reg_pkg::regval_t a,
		input ecc_reg_pkg::regval_t b);
		logic [63:0] s;
		s = 64'(a) + 64'(`ECC_PRIME) - 64'(b);
		return ecc_reg_pkg::regval_t'(s % 64'(`ECC_PRIME));
	endfunction

	function automatic bit writable(input ecc_reg_pkg::regid_t id);
		return int'(id) <= `ECC_LAST_GPR;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus tasks

	// Random residue below the prime
	task automatic draw_residue(output ecc_reg_pkg::regval_t v);
		logic [31:0] r;
		r = $random(seed);
		v = r % `ECC_PRIME;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		errs_at_start = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-12s %s (%0d errors)", cur_test,
			(errors == errs_at_start) ? "ok" : "failed", errors - errs_at_start);
	endtask

	// Load strobe for one cycle, written on the sampling edge
	task automatic load_reg(input ecc_reg_pkg::regid_t id, input ecc_reg_pkg::regval_t val);
		@(posedge clk);
		load_en   <= 1'b1;
		load_addr <= id;
		load_data <= val;
		@(posedge clk);
		load_en   <= 1'b0;
		if (writable(id)) begin
			model[id] = val;
		end
	endtask

	// One issue, then hold off until the results have landed
	task automatic run_op(input ecc_op_pkg::opcode_t op, input ecc_reg_pkg::regid_t a,
		input ecc_reg_pkg::regid_t b, input ecc_reg_pkg::regid_t ds,
		input ecc_reg_pkg::regid_t dd);
		ecc_reg_pkg::regval_t va;
		ecc_reg_pkg::regval_t vb;
		va = model[a];
		vb = model[b];
		@(posedge clk);
		issue_en       <= 1'b1;
		issue_op       <= op;
		issue_src_a    <= a;
		issue_src_b    <= b;
		issue_dst_sum  <= ds;
		issue_dst_diff <= dd;
		@(posedge clk);
		issue_en       <= 1'b0;
		issue_op       <= ecc_op_pkg::op_nop;
		repeat (RETIRE_LATENCY) @(posedge clk);
		if ((op == ecc_op_pkg::op_add || op == ecc_op_pkg::op_addsub) && writable(ds)) begin
			model[ds] = mod_add(va, vb);
		end
		// Port 1 lands last in the model, same as the live value table
		if ((op == ecc_op_pkg::op_sub || op == ecc_op_pkg::op_addsub) && writable(dd)) begin
			model[dd] = mod_sub(va, vb);
		end
	endtask

	// Read request, wait for rd_valid, compare with the model
	task automatic check_reg(input ecc_reg_pkg::regid_t id);
		int waited;
		bit seen;
		waited = 0;
		seen = 1'b0;
		@(posedge clk);
		rd_req  <= 1'b1;
		rd_addr <= id;
		@(posedge clk);
		rd_req  <= 1'b0;
		// Outputs sampled mid-cycle
		while (!seen && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			if (rd_valid) begin
				seen = 1'b1;
			end else begin
				waited++;
			end
		end
		checks++;
		assert (seen) else begin
			$display("%s: no rd_valid for register %0d within %0d cycles", cur_test,
				int'(id), TIMEOUT_CYCLES);
			errors++;
		end
		if (seen) begin
			assert (rd_data == model[id]) else begin
				$display("ERROR %s: reg %0d expected %08h actual %08h", cur_test, int'(id),
					model[id], rd_data);
				errors++;
			end
			// Pulse must drop again after one cycle
			@(negedge clk);
			assert (!rd_valid) else begin
				$display("%s: rd_valid stayed high for more than one cycle", cur_test);
				errors++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		ecc_reg_pkg::regval_t v;
		seed = SEED_INIT;
		errors = 0;
		checks = 0;
		tests = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		load_en = 1'b0;
		load_addr = ecc_reg_pkg::reg_r0;
		load_data = '0;
		issue_en = 1'b0;
		issue_op = ecc_op_pkg::op_nop;
		issue_src_a = ecc_reg_pkg::reg_r0;
		issue_src_b = ecc_reg_pkg::reg_r0;
		issue_dst_sum = ecc_reg_pkg::reg_r0;
		issue_dst_diff = ecc_reg_pkg::reg_r0;
		rd_req = 1'b0;
		rd_addr = ecc_reg_pkg::reg_r0;
		// Power-up contents: GPRs clear, then 0, 1, 121665
		for (int i = 0; i < `ECC_REG_COUNT; i++) begin
			model[i] = '0;
		end
		model[ecc_reg_pkg::reg_one] = 32'd1;
		model[ecc_reg_pkg::reg_a24] = `ECC_CONST_121665;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		start_test("reset");
		for (int i = 0; i < `ECC_REG_COUNT; i++) begin
			check_reg(ecc_reg_pkg::regid_t'(i));
		end
		end_test();

		start_test("load");
		for (int i = 0; i <= `ECC_LAST_GPR; i++) begin
			draw_residue(v);
			load_reg(ecc_reg_pkg::regid_t'(i), v);
		end
		for (int i = 0; i <= `ECC_LAST_GPR; i++) begin
			check_reg(ecc_reg_pkg::regid_t'(i));
		end
		end_test();

		// Random pairs, then operands right below p
		start_test("mod_add");
		for (int k = 0; k < 4; k++) begin
			run_op(ecc_op_pkg::op_add, ecc_reg_pkg::regid_t'(k), ecc_reg_pkg::regid_t'(k + 4),
				ecc_reg_pkg::regid_t'(k + 8), ecc_reg_pkg::reg_r12);
			check_reg(ecc_reg_pkg::regid_t'(k + 8));
		end
		// Unwanted difference must not land
		check_reg(ecc_reg_pkg::reg_r12);
		load_reg(ecc_reg_pkg::reg_r0, `ECC_PRIME - 32'd1);
		load_reg(ecc_reg_pkg::reg_r1, `ECC_PRIME - 32'd2);
		load_reg(ecc_reg_pkg::reg_r3, 32'd1);
		run_op(ecc_op_pkg::op_add, ecc_reg_pkg::reg_r0, ecc_reg_pkg::reg_r1,
			ecc_reg_pkg::reg_r2, ecc_reg_pkg::reg_r12);
		check_reg(ecc_reg_pkg::reg_r2);
		// p-1 plus one wraps to zero
		run_op(ecc_op_pkg::op_add, ecc_reg_pkg::reg_r0, ecc_reg_pkg::reg_r3,
			ecc_reg_pkg::reg_r4, ecc_reg_pkg::reg_r12);
		check_reg(ecc_reg_pkg::reg_r4);
		run_op(ecc_op_pkg::op_add, ecc_reg_pkg::reg_r0, ecc_reg_pkg::reg_one,
			ecc_reg_pkg::reg_r5, ecc_reg_pkg::reg_r12);
		check_reg(ecc_reg_pkg::reg_r5);
		end_test();

		start_test("mod_sub");
		for (int k = 0; k < 3; k++) begin
			run_op(ecc_op_pkg::op_sub, ecc_reg_pkg::regid_t'(k + 8), ecc_reg_pkg::regid_t'(k),
				ecc_reg_pkg::reg_r11, ecc_reg_pkg::regid_t'(k + 4));
			check_reg(ecc_reg_pkg::regid_t'(k + 4));
		end
		check_reg(ecc_reg_pkg::reg_r11);
		load_reg(ecc_reg_pkg::reg_r5, 32'd5);
		load_reg(ecc_reg_pkg::reg_r6, 32'd9);
		// a < b, must wrap to p-4
		run_op(ecc_op_pkg::op_sub, ecc_reg_pkg::reg_r5, ecc_reg_pkg::reg_r6,
			ecc_reg_pkg::reg_r11, ecc_reg_pkg::reg_r7);
		check_reg(ecc_reg_pkg::reg_r7);
		run_op(ecc_op_pkg::op_sub, ecc_reg_pkg::reg_r5, ecc_reg_pkg::reg_r5,
			ecc_reg_pkg::reg_r11, ecc_reg_pkg::reg_r8);
		check_reg(ecc_reg_pkg::reg_r8);
		run_op(ecc_op_pkg::op_sub, ecc_reg_pkg::reg_zero, ecc_reg_pkg::reg_r6,
			ecc_reg_pkg::reg_r11, ecc_reg_pkg::reg_r9);
		check_reg(ecc_reg_pkg::reg_r9);
		end_test();

		// Bank switching through the live value table
		start_test("addsub_lvt");
		draw_residue(v);
		load_reg(ecc_reg_pkg::reg_r0, v);
		draw_residue(v);
		load_reg(ecc_reg_pkg::reg_r1, v);
		run_op(ecc_op_pkg::op_addsub, ecc_reg_pkg::reg_r0, ecc_reg_pkg::reg_r1,
			ecc_reg_pkg::reg_r2, ecc_reg_pkg::reg_r3);
		check_reg(ecc_reg_pkg::reg_r2);
		check_reg(ecc_reg_pkg::reg_r3);
		// r3 moves from bank 1 back to bank 0
		run_op(ecc_op_pkg::op_add, ecc_reg_pkg::reg_r2, ecc_reg_pkg::reg_r1,
			ecc_reg_pkg::reg_r3, ecc_reg_pkg::reg_r12);
		check_reg(ecc_reg_pkg::reg_r3);
		check_reg(ecc_reg_pkg::reg_r2);
		run_op(ecc_op_pkg::op_addsub, ecc_reg_pkg::reg_r3, ecc_reg_pkg::reg_r0,
			ecc_reg_pkg::reg_r4, ecc_reg_pkg::reg_r2);
		check_reg(ecc_reg_pkg::reg_r2);
		check_reg(ecc_reg_pkg::reg_r4);
		check_reg(ecc_reg_pkg::reg_r3);
		end_test();

		// Loads and retires into constants
		start_test("const");
		for (int i = `ECC_LAST_GPR + 1; i < `ECC_REG_COUNT; i++) begin
			draw_residue(v);
			load_reg(ecc_reg_pkg::regid_t'(i), v);
		end
		run_op(ecc_op_pkg::op_addsub, ecc_reg_pkg::reg_r0, ecc_reg_pkg::reg_r1,
			ecc_reg_pkg::reg_one, ecc_reg_pkg::reg_a24);
		run_op(ecc_op_pkg::op_sub, ecc_reg_pkg::reg_r1, ecc_reg_pkg::reg_r0,
			ecc_reg_pkg::reg_r9, ecc_reg_pkg::reg_zero);
		for (int i = `ECC_LAST_GPR + 1; i < `ECC_REG_COUNT; i++) begin
			check_reg(ecc_reg_pkg::regid_t'(i));
		end
		check_reg(ecc_reg_pkg::reg_r9);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
rtl/ecc_reg_pkg.sv
rtl/ecc_op_pkg.sv
rtl/retire_if.sv
rtl/regfile_bank.sv
rtl/regfile.sv
rtl/modaddsub_unit.sv
rtl/ecc_field_core.sv
tests/tb_ecc_field_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

# Build the testbench with assertions and timing enabled
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module tb_ecc_field_core -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
exit 0
